// File: source/lane_consts.svh
// Lane sizing constants
// Engine count, data, address, engine index and run count widths
// FIFO depth for the lane input and output buffers

`ifndef LANE_CONSTS_SVH
`define LANE_CONSTS_SVH

// --------------------
// Lane structure
// --------------------
`define LANE_NUM_ENGINES 4
`define LANE_FIFO_DEPTH  8

// --------------------
// Widths
// --------------------
`define LANE_DATA_W  32
`define LANE_ADDR_W  8
// Must cover LANE_NUM_ENGINES
`define LANE_ID_W    2
`define LANE_COUNT_W 16

`endif

// File: source/lane_pkg.sv
// Lane package
// Data, address, engine index and run count types
// Operation enum and the engine and arbiter state enums

`default_nettype none

`include "lane_consts.svh"

package lane_pkg;

    typedef logic [`LANE_DATA_W-1:0]  lane_data_t;
    typedef logic [`LANE_ADDR_W-1:0]  lane_addr_t;
    typedef logic [`LANE_ID_W-1:0]    lane_id_t;
    typedef logic [`LANE_COUNT_W-1:0] lane_count_t;

    // Descriptor operation codes
    typedef enum logic [1:0] {
        LANE_OP_PASS = 2'd0,
        LANE_OP_ADD  = 2'd1,
        LANE_OP_XOR  = 2'd2
    } lane_op_e;

    typedef enum logic [1:0] {ENG_IDLE, ENG_READ, ENG_SEND} engine_state_e;

    // Four-phase memory port sequence
    typedef enum logic [1:0] {ARB_IDLE, ARB_REQ, ARB_RELEASE} arb_state_e;

endpackage

`default_nettype wire

// File: source/packet_fifo.sv
// Synchronous first-word-fall-through FIFO
// Circular buffer with occupancy count, head word visible while not empty

`timescale 1ns/100ps
`default_nettype none

module packet_fifo #(
    parameter int WIDTH = 40,
    parameter int DEPTH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_lane_template,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic             full_o,
    output logic             empty_o,
    output logic [WIDTH-1:0] head_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o      = (count_q == CNT_W'(DEPTH));
    assign empty_o     = (count_q == '0);
    assign do_push     = push_i && !full_o;
    assign do_pop      = pop_i && !empty_o;
    assign head_data_o = mem_q[rd_ptr_q];

    // Pointers and occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

`default_nettype wire

// File: source/lane_engine.sv
// Lane engine stage
// Holds one packet, reads one memory word unless the run is PASS,
// combines it with the packet value and forwards downstream.
// Counts forwarded packets against the run count for done

`timescale 1ns/100ps
`default_nettype none

`include "lane_consts.svh"

module lane_engine #(
    parameter int ENGINE_ID = 0
) (
    input  logic                  ap_clk,
    input  logic                  areset_lane_template,
    input  logic                  desc_start_i,
    input  lane_pkg::lane_op_e    desc_op_i,
    input  lane_pkg::lane_count_t desc_count_i,
    input  logic                  pkt_in_valid_i,
    input  lane_pkg::lane_addr_t  pkt_in_addr_i,
    input  lane_pkg::lane_data_t  pkt_in_value_i,
    output logic                  pkt_in_ready_o,
    output logic                  pkt_out_valid_o,
    output lane_pkg::lane_addr_t  pkt_out_addr_o,
    output lane_pkg::lane_data_t  pkt_out_value_o,
    input  logic                  pkt_out_ready_i,
    output logic                  rd_req_o,
    output lane_pkg::lane_addr_t  rd_addr_o,
    input  logic                  rd_ack_i,
    input  lane_pkg::lane_data_t  rd_data_i,
    output logic                  done_o
);

    import lane_pkg::*;

    engine_state_e state_q;
    lane_op_e      op_q;
    lane_count_t   count_q;
    lane_count_t   sent_q;
    lane_addr_t    addr_q;
    lane_data_t    value_q;
    logic          accept;
    logic          forward;

    // Engine index must address the shared memory port
    if (ENGINE_ID >= `LANE_NUM_ENGINES) begin : g_bad_id
        $error("lane_engine ENGINE_ID out of range");
    end

    function automatic lane_data_t combine(
        input lane_op_e   op,
        input lane_data_t value,
        input lane_data_t word
    );
        lane_data_t result;
        case (op)
            LANE_OP_ADD: result = value + word;
            LANE_OP_XOR: result = value ^ word;
            default:     result = value;
        endcase
        return result;
    endfunction

    // --------------------
    // Handshakes
    // --------------------
    assign pkt_in_ready_o  = (state_q == ENG_IDLE);
    assign pkt_out_valid_o = (state_q == ENG_SEND);
    assign pkt_out_addr_o  = addr_q;
    assign pkt_out_value_o = value_q;
    assign rd_req_o        = (state_q == ENG_READ);
    assign rd_addr_o       = addr_q;

    assign accept  = pkt_in_valid_i && pkt_in_ready_o;
    assign forward = pkt_out_valid_o && pkt_out_ready_i;

    assign done_o = (sent_q == count_q);

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            state_q <= ENG_IDLE;
            op_q    <= LANE_OP_PASS;
            count_q <= '0;
            sent_q  <= '0;
        end else begin
            if (desc_start_i) begin
                op_q    <= desc_op_i;
                count_q <= desc_count_i;
                sent_q  <= '0;
            end else if (forward) begin
                sent_q <= sent_q + 1'b1;
            end

            case (state_q)
                ENG_IDLE: begin
                    if (accept) begin
                        // PASS skips the memory read
                        state_q <= (op_q == LANE_OP_PASS) ? ENG_SEND : ENG_READ;
                    end
                end
                ENG_READ: begin
                    if (rd_ack_i) begin
                        state_q <= ENG_SEND;
                    end
                end
                ENG_SEND: begin
                    if (pkt_out_ready_i) begin
                        state_q <= ENG_IDLE;
                    end
                end
                default: state_q <= ENG_IDLE;
            endcase
        end
    end

    // Packet held in the stage
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            addr_q  <= pkt_in_addr_i;
            value_q <= pkt_in_value_i;
        end else if (state_q == ENG_READ && rd_ack_i) begin
            value_q <= combine(op_q, value_q, rd_data_i);
        end
    end

endmodule

`default_nettype wire

// File: source/memory_port_arbiter.sv
// Round-robin arbiter for the shared memory read port
// Runs the four-phase req/ack handshake and returns the word
// to the granted engine with a one-cycle ack

`timescale 1ns/100ps
`default_nettype none

`include "lane_consts.svh"

module memory_port_arbiter (
    input  logic                          ap_clk,
    input  logic                          areset_lane_template,
    input  logic [`LANE_NUM_ENGINES-1:0]  rd_req_i,
    input  lane_pkg::lane_addr_t          rd_addr_i [`LANE_NUM_ENGINES],
    output logic [`LANE_NUM_ENGINES-1:0]  rd_ack_o,
    output lane_pkg::lane_data_t          rd_data_o,
    output logic                          mem_req_o,
    output lane_pkg::lane_addr_t          mem_addr_o,
    output lane_pkg::lane_id_t            mem_id_o,
    input  logic                          mem_ack_i,
    input  lane_pkg::lane_data_t          mem_data_i
);

    import lane_pkg::*;

    localparam int NUM_ENG = `LANE_NUM_ENGINES;

    arb_state_e           state_q;
    lane_id_t             grant_q;
    logic [NUM_ENG-1:0]   ack_q;
    lane_addr_t           addr_q;
    lane_data_t           data_q;
    logic [NUM_ENG-1:0]   req_eff;
    logic                 pick_valid;
    lane_id_t             pick_id;

    // An engine still shows its request in the cycle its ack is out
    assign req_eff = rd_req_i & ~ack_q;

    // Next requester after the last grant
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_id    = grant_q;
        for (int off = 1; off <= NUM_ENG; off++) begin
            idx = (int'(grant_q) + off) % NUM_ENG;
            if (req_eff[idx] && !pick_valid) begin
                pick_valid = 1'b1;
                pick_id    = lane_id_t'(idx);
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_lane_template) begin
            state_q <= ARB_IDLE;
            grant_q <= lane_id_t'(NUM_ENG - 1);
            ack_q   <= '0;
        end else begin
            ack_q <= '0;
            case (state_q)
                ARB_IDLE: begin
                    if (pick_valid) begin
                        grant_q <= pick_id;
                        state_q <= ARB_REQ;
                    end
                end
                ARB_REQ: begin
                    if (mem_ack_i) begin
                        state_q <= ARB_RELEASE;
                    end
                end
                ARB_RELEASE: begin
                    // Wait for memory to drop ack before answering
                    if (!mem_ack_i) begin
                        ack_q[grant_q] <= 1'b1;
                        state_q        <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state_q == ARB_IDLE && pick_valid) begin
            addr_q <= rd_addr_i[pick_id];
        end
        if (state_q == ARB_REQ && mem_ack_i) begin
            data_q <= mem_data_i;
        end
    end

    assign mem_req_o  = (state_q == ARB_REQ);
    assign mem_addr_o = addr_q;
    assign mem_id_o   = grant_q;
    assign rd_ack_o   = ack_q;
    assign rd_data_o  = data_q;

endmodule

`default_nettype wire

// File: source/lane_top.sv
// Lane top level
// Input FIFO, chain of engines, output FIFO,
// shared memory port arbiter and the lane done reduction

`timescale 1ns/100ps
`default_nettype none

`include "lane_consts.svh"

module lane_top (
    input  logic                  ap_clk,
    input  logic                  areset_lane_template,
    input  logic                  lane_in_valid_i,
    input  lane_pkg::lane_addr_t  lane_in_addr_i,
    input  lane_pkg::lane_data_t  lane_in_value_i,
    output logic                  lane_in_ready_o,
    output logic                  lane_out_valid_o,
    output lane_pkg::lane_addr_t  lane_out_addr_o,
    output lane_pkg::lane_data_t  lane_out_value_o,
    input  logic                  lane_out_ready_i,
    input  logic                  desc_start_i,
    input  lane_pkg::lane_op_e    desc_op_i,
    input  lane_pkg::lane_count_t desc_count_i,
    output logic                  mem_req_o,
    output lane_pkg::lane_addr_t  mem_addr_o,
    output lane_pkg::lane_id_t    mem_id_o,
    input  logic                  mem_ack_i,
    input  lane_pkg::lane_data_t  mem_data_i,
    output logic                  done_o
);

    import lane_pkg::*;

    localparam int NUM_ENG = `LANE_NUM_ENGINES;
    localparam int PKT_W   = `LANE_ADDR_W + `LANE_DATA_W;

    // Stage 0 is the input FIFO head, stage NUM_ENG feeds the output FIFO
    logic [NUM_ENG:0]   chain_valid;
    logic [NUM_ENG:0]   chain_ready;
    lane_addr_t         chain_addr  [NUM_ENG+1];
    lane_data_t         chain_value [NUM_ENG+1];

    logic [NUM_ENG-1:0] eng_rd_req;
    lane_addr_t         eng_rd_addr [NUM_ENG];
    logic [NUM_ENG-1:0] eng_rd_ack;
    lane_data_t         rd_data;
    logic [NUM_ENG-1:0] eng_done;

    logic               in_full;
    logic               in_empty;
    logic [PKT_W-1:0]   in_head;
    logic               out_full;
    logic               out_empty;
    logic [PKT_W-1:0]   out_head;

    // --------------------
    // Input FIFO
    // --------------------
    assign lane_in_ready_o = !in_full;
    assign chain_valid[0]  = !in_empty;
    assign {chain_addr[0], chain_value[0]} = in_head;

    packet_fifo #(.WIDTH(PKT_W), .DEPTH(`LANE_FIFO_DEPTH)) u_in_fifo (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .push_i               (lane_in_valid_i && lane_in_ready_o),
        .push_data_i          ({lane_in_addr_i, lane_in_value_i}),
        .pop_i                (chain_valid[0] && chain_ready[0]),
        .full_o               (in_full),
        .empty_o              (in_empty),
        .head_data_o          (in_head)
    );

    // --------------------
    // Engine chain
    // --------------------
    for (genvar e = 0; e < NUM_ENG; e++) begin : g_engine
        lane_engine #(.ENGINE_ID(e)) u_engine (
            .ap_clk               (ap_clk),
            .areset_lane_template (areset_lane_template),
            .desc_start_i         (desc_start_i),
            .desc_op_i            (desc_op_i),
            .desc_count_i         (desc_count_i),
            .pkt_in_valid_i       (chain_valid[e]),
            .pkt_in_addr_i        (chain_addr[e]),
            .pkt_in_value_i       (chain_value[e]),
            .pkt_in_ready_o       (chain_ready[e]),
            .pkt_out_valid_o      (chain_valid[e+1]),
            .pkt_out_addr_o       (chain_addr[e+1]),
            .pkt_out_value_o      (chain_value[e+1]),
            .pkt_out_ready_i      (chain_ready[e+1]),
            .rd_req_o             (eng_rd_req[e]),
            .rd_addr_o            (eng_rd_addr[e]),
            .rd_ack_i             (eng_rd_ack[e]),
            .rd_data_i            (rd_data),
            .done_o               (eng_done[e])
        );
    end

    memory_port_arbiter u_arbiter (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .rd_req_i             (eng_rd_req),
        .rd_addr_i            (eng_rd_addr),
        .rd_ack_o             (eng_rd_ack),
        .rd_data_o            (rd_data),
        .mem_req_o            (mem_req_o),
        .mem_addr_o           (mem_addr_o),
        .mem_id_o             (mem_id_o),
        .mem_ack_i            (mem_ack_i),
        .mem_data_i           (mem_data_i)
    );

    // --------------------
    // Output FIFO
    // --------------------
    // Last engine stalls in its send state while this fills
    assign chain_ready[NUM_ENG] = !out_full;
    assign lane_out_valid_o     = !out_empty;
    assign {lane_out_addr_o, lane_out_value_o} = out_head;

    packet_fifo #(.WIDTH(PKT_W), .DEPTH(`LANE_FIFO_DEPTH)) u_out_fifo (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .push_i               (chain_valid[NUM_ENG] && chain_ready[NUM_ENG]),
        .push_data_i          ({chain_addr[NUM_ENG], chain_value[NUM_ENG]}),
        .pop_i                (lane_out_valid_o && lane_out_ready_i),
        .full_o               (out_full),
        .empty_o              (out_empty),
        .head_data_o          (out_head)
    );

    assign done_o = &eng_done;

endmodule

`default_nettype wire

// File: bench/lane_chk.sv
// Bound checks on the lane top level
// Four-phase memory request hold and address stability,
// output packet hold under back-pressure

`timescale 1ns/100ps
`default_nettype none

module lane_chk (
    input logic                 ap_clk,
    input logic                 areset_lane_template,
    input logic                 mem_req_i,
    input logic                 mem_ack_i,
    input lane_pkg::lane_addr_t mem_addr_i,
    input lane_pkg::lane_id_t   mem_id_i,
    input logic                 out_valid_i,
    input logic                 out_ready_i,
    input lane_pkg::lane_addr_t out_addr_i,
    input lane_pkg::lane_data_t out_value_i
);

    // Request may only fall after memory has answered
    a_req_hold: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        (mem_req_i && !mem_ack_i) |=> mem_req_i)
        else $error("mem_req_o fell before mem_ack_i rose");

    // One transaction keeps its address and engine index
    a_req_stable: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        (mem_req_i && $past(mem_req_i)) |-> ($stable(mem_addr_i) && $stable(mem_id_i)))
        else $error("mem_addr_o or mem_id_o changed during a memory request");

    // Stalled output packet holds
    a_out_hold: assert property (@(posedge ap_clk) disable iff (areset_lane_template)
        (out_valid_i && !out_ready_i) |=>
            (out_valid_i && $stable(out_addr_i) && $stable(out_value_i)))
        else $error("lane output changed while stalled");

endmodule

bind lane_top lane_chk u_lane_chk (
    .ap_clk               (ap_clk),
    .areset_lane_template (areset_lane_template),
    .mem_req_i            (mem_req_o),
    .mem_ack_i            (mem_ack_i),
    .mem_addr_i           (mem_addr_o),
    .mem_id_i             (mem_id_o),
    .out_valid_i          (lane_out_valid_o),
    .out_ready_i          (lane_out_ready_i),
    .out_addr_i           (lane_out_addr_o),
    .out_value_i          (lane_out_value_o)
);

`default_nettype wire

// File: bench/lane_tb.sv
// Lane testbench
// Clock, reset, packet stimulus, four-phase memory model,
// reference function and output comparison for lane_top

`timescale 1ns/100ps
`default_nettype none

`include "lane_consts.svh"

module lane_tb;

    import lane_pkg::*;

    localparam int PKT_W        = `LANE_ADDR_W + `LANE_DATA_W;
    localparam int WAIT_LIMIT   = 2000;
    localparam int ADD_PACKETS  = 20;
    localparam int XOR_PACKETS  = 24;
    localparam int PASS_PACKETS = 12;

    logic        ap_clk = 1'b0;
    logic        areset_lane_template;
    logic        lane_in_valid_i;
    lane_addr_t  lane_in_addr_i;
    lane_data_t  lane_in_value_i;
    logic        lane_in_ready_o;
    logic        lane_out_valid_o;
    lane_addr_t  lane_out_addr_o;
    lane_data_t  lane_out_value_o;
    logic        lane_out_ready_i = 1'b0;
    logic        desc_start_i;
    lane_op_e    desc_op_i;
    lane_count_t desc_count_i;
    logic        mem_req_o;
    lane_addr_t  mem_addr_o;
    lane_id_t    mem_id_o;
    logic        mem_ack_i = 1'b0;
    lane_data_t  mem_data_i = '0;
    logic        done_o;

    logic [PKT_W-1:0] expected_q [$];
    string       test_name = "";
    logic        throttle_out = 1'b0;
    int          mem_delay = 0;
    int          mem_busy_cycles = 0;
    int          check_count = 0;
    int          error_count = 0;
    bit          timed_out = 1'b0;

    lane_top u_lane_top (
        .ap_clk               (ap_clk),
        .areset_lane_template (areset_lane_template),
        .lane_in_valid_i      (lane_in_valid_i),
        .lane_in_addr_i       (lane_in_addr_i),
        .lane_in_value_i      (lane_in_value_i),
        .lane_in_ready_o      (lane_in_ready_o),
        .lane_out_valid_o     (lane_out_valid_o),
        .lane_out_addr_o      (lane_out_addr_o),
        .lane_out_value_o     (lane_out_value_o),
        .lane_out_ready_i     (lane_out_ready_i),
        .desc_start_i         (desc_start_i),
        .desc_op_i            (desc_op_i),
        .desc_count_i         (desc_count_i),
        .mem_req_o            (mem_req_o),
        .mem_addr_o           (mem_addr_o),
        .mem_id_o             (mem_id_o),
        .mem_ack_i            (mem_ack_i),
        .mem_data_i           (mem_data_i),
        .done_o               (done_o)
    );

    always #20 ap_clk = ~ap_clk;

    // --------------------
    // Memory contents and reference model
    // --------------------
    function automatic lane_data_t mem_word(input lane_id_t id, input lane_addr_t addr);
        lane_data_t scrambled;
        scrambled = lane_data_t'(addr) * 32'h9e37_79b1;
        return scrambled ^ {id, 6'h15, addr, 16'hc3a5};
    endfunction

    // Each engine in turn applies the run operation with its own word
    function automatic lane_data_t expected_value(
        input lane_op_e   op,
        input lane_addr_t addr,
        input lane_data_t value
    );
        lane_data_t acc;
        acc = value;
        for (int e = 0; e < `LANE_NUM_ENGINES; e++) begin
            if (op == LANE_OP_ADD) begin
                acc = acc + mem_word(lane_id_t'(e), addr);
            end else if (op == LANE_OP_XOR) begin
                acc = acc ^ mem_word(lane_id_t'(e), addr);
            end
        end
        return acc;
    endfunction

    // Four-phase responder with random latency on both edges of ack
    always @(posedge ap_clk) begin
        if (areset_lane_template) begin
            mem_ack_i <= 1'b0;
            mem_delay <= 0;
        end else if (!mem_ack_i) begin
            if (mem_req_o && mem_delay == 0) begin
                mem_ack_i  <= 1'b1;
                mem_data_i <= mem_word(mem_id_o, mem_addr_o);
                mem_delay  <= int'($urandom % 4);
            end else if (mem_req_o) begin
                mem_delay <= mem_delay - 1;
            end
        end else if (!mem_req_o) begin
            if (mem_delay == 0) begin
                mem_ack_i <= 1'b0;
                mem_delay <= int'($urandom % 6);
            end else begin
                mem_delay <= mem_delay - 1;
            end
        end
    end

    always @(posedge ap_clk) begin
        if (mem_req_o) begin
            mem_busy_cycles <= mem_busy_cycles + 1;
        end
    end

    // Output back-pressure with ready one cycle in four when throttled
    always @(posedge ap_clk) begin
        if (throttle_out) begin
            lane_out_ready_i <= (($urandom % 4) == 0);
        end else begin
            lane_out_ready_i <= 1'b1;
        end
    end

    // --------------------
    // Checks and run tasks
    // --------------------
    task automatic check_value(
        input string       name,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        timed_out = 1'b1;
        $display("TIMEOUT in %s: %s", test_name, what);
    endtask

    task automatic start_run(input lane_op_e op, input int count);
        @(posedge ap_clk);
        desc_start_i <= 1'b1;
        desc_op_i    <= op;
        desc_count_i <= lane_count_t'(count);
        @(posedge ap_clk);
        desc_start_i <= 1'b0;
        @(posedge ap_clk);
        check_value({test_name, " done low"}, 64'd0, 64'(done_o));
    endtask

    task automatic send_packets(input lane_op_e op, input int count);
        lane_addr_t addr;
        lane_data_t value;
        int         waited;
        bit         accepted;
        for (int i = 0; i < count; i++) begin
            addr  = lane_addr_t'($urandom);
            value = lane_data_t'($urandom);
            expected_q.push_back({addr, expected_value(op, addr, value)});
            lane_in_valid_i <= 1'b1;
            lane_in_addr_i  <= addr;
            lane_in_value_i <= value;
            waited = 0;
            do begin
                @(posedge ap_clk);
                waited++;
                accepted = lane_in_ready_o;
            end while (!accepted && waited < WAIT_LIMIT);
            if (!accepted) begin
                lane_in_valid_i <= 1'b0;
                report_timeout("input FIFO never accepted a packet");
                return;
            end
            // Occasional idle cycle between packets
            if (($urandom % 4) == 0) begin
                lane_in_valid_i <= 1'b0;
                @(posedge ap_clk);
            end
        end
        lane_in_valid_i <= 1'b0;
    endtask

    task automatic collect_packets(input int count);
        logic [PKT_W-1:0] exp_pkt;
        int               waited;
        bit               seen;
        for (int i = 0; i < count; i++) begin
            waited = 0;
            do begin
                @(posedge ap_clk);
                waited++;
                seen = lane_out_valid_o && lane_out_ready_i;
            end while (!seen && waited < WAIT_LIMIT);
            if (!seen) begin
                report_timeout("no packet left the lane");
                return;
            end
            if (expected_q.size() == 0) begin
                error_count++;
                $display("ERROR in %s: a packet left the lane that was never sent", test_name);
            end else begin
                exp_pkt = expected_q.pop_front();
                check_value(test_name, 64'(exp_pkt),
                            64'({lane_out_addr_o, lane_out_value_o}));
            end
        end
    endtask

    task automatic run_lane(input string name, input lane_op_e op, input int count);
        if (timed_out) begin
            return;
        end
        test_name = name;
        start_run(op, count);
        fork
            send_packets(op, count);
            collect_packets(count);
        join
        @(posedge ap_clk);
        check_value({name, " done high"}, 64'd1, 64'(done_o));
        check_value({name, " leftover"}, 64'd0, 64'(expected_q.size()));
        check_value({name, " output idle"}, 64'd0, 64'(lane_out_valid_o));
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int busy_before;
        void'($urandom(32'h6eef));
        areset_lane_template <= 1'b1;
        lane_in_valid_i      <= 1'b0;
        lane_in_addr_i       <= '0;
        lane_in_value_i      <= '0;
        desc_start_i         <= 1'b0;
        desc_op_i            <= LANE_OP_PASS;
        desc_count_i         <= '0;
        repeat (10) @(posedge ap_clk);
        areset_lane_template <= 1'b0;
        @(posedge ap_clk);

        test_name = "reset";
        check_value("reset done", 64'd1, 64'(done_o));
        check_value("reset out valid", 64'd0, 64'(lane_out_valid_o));
        check_value("reset mem req", 64'd0, 64'(mem_req_o));

        run_lane("add_run", LANE_OP_ADD, ADD_PACKETS);

        throttle_out <= 1'b1;
        run_lane("xor_run", LANE_OP_XOR, XOR_PACKETS);
        throttle_out <= 1'b0;

        busy_before = mem_busy_cycles;
        run_lane("pass_run", LANE_OP_PASS, PASS_PACKETS);
        check_value("pass_run memory idle", 64'(busy_before), 64'(mem_busy_cycles));

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/lane_pkg.sv
source/packet_fifo.sv
source/lane_engine.sv
source/memory_port_arbiter.sv
source/lane_top.sv
bench/lane_chk.sv
bench/lane_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module lane_tb -f tb.f

status=0
./obj_dir/Vlane_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Simulation PASSED" "$LOG"; then
    echo "Simulation did not complete, see $LOG"
    exit 1
fi
exit 0
